//--- sim/decode_input.txt
# inst ex_valid ex_inst ready_pattern flush exp_op exp_imm src_b_tag
# src_b_tag 1000 = gpr[rs2], 2000 = zero, otherwise the csr address that is read
00510093 0 00000000 ff 0 08 0000000000000005 1000
fff20193 0 00000000 a5 0 08 ffffffffffffffff 1000
123452b7 0 00000000 ff 0 01 0000000012345000 1000
80000337 0 00000000 3c 0 01 ffffffff80000000 1000
00001397 0 00000000 ff 0 02 0000000000001000 1000
001000ef 0 00000000 ff 0 03 0000000000000800 1000
ffdff06f 0 00000000 0e 0 03 fffffffffffffffc 1000
008100e7 0 00000000 ff 0 04 0000000000000008 1000
00208863 0 00000000 ff 0 05 0000000000000010 1000
fe419ce3 0 00000000 96 0 05 fffffffffffffff8 1000
0104b403 0 00000000 ff 0 06 0000000000000010 1000
fea5bc23 0 00000000 ff 0 07 fffffffffffffff8 1000
0016861b 0 00000000 ff 0 09 0000000000000001 1000
01078733 1 0000b803 ff 0 0a 0000000000000010 1000
403100b3 0 00000000 ff 0 0a 0000000000000403 1000
007302bb 0 00000000 ff 0 0b 0000000000000007 1000
00510093 1 0000b103 ff 0 08 0000000000000005 1000
00510093 1 0000b283 ff 0 08 0000000000000005 1000
305110f3 0 00000000 ff 0 0c 0000000000000305 0305
342021f3 0 00000000 ff 0 0d 0000000000000342 0342
00510093 0 00000000 00 1 00 0000000000000000 1000
30002273 0 00000000 ff 0 0d 0000000000000300 0300
7c009073 0 00000000 ff 0 0c 00000000000007c0 2000
00000073 0 00000000 ff 0 0e 0000000000000000 0305
30200073 0 00000000 ff 0 0f 0000000000000302 0341
00100073 0 00000000 ff 0 10 0000000000000001 1000
ffffffff 0 00000000 ff 0 00 ffffffffffffffff 1000

//--- compile.f
source/decode_pkg.sv
source/fetch_buffer.sv
source/decode_reg.sv
source/load_interlock.sv
source/inst_decoder.sv
source/operand_select.sv
source/decode_stage.sv
sim/decode_stage_assert.sv
sim/decode_stage_tb.sv

//--- sim/decode_stage_tb.sv
`timescale 1ns/1ps

module decode_stage_tb;

    localparam int XLEN          = decode_pkg::XLEN;
    localparam int ILEN          = decode_pkg::ILEN;
    localparam int DEPTH         = 16;
    localparam int ALMOST_FULL   = 12;
    localparam int CLK_PERIOD    = 100;
    localparam int DRIVE_DELAY   = 5;                 // after rising edge
    localparam int RESET_CYCLES  = 16;
    localparam int HAZARD_CYCLES = 3;                 // cycles a record's ex inst stays valid
    localparam logic [XLEN-1:0] MSTATUS_WORD = 64'h0000_0000_0000_1800;
    localparam logic [XLEN-1:0] MTVEC_WORD   = 64'h0000_0000_8000_0100;
    localparam logic [XLEN-1:0] MEPC_WORD    = 64'h0000_0000_8000_2000;
    localparam logic [XLEN-1:0] MCAUSE_WORD  = 64'h8000_0000_0000_000b;

    logic            clk = 1'b0;
    logic            rst;
    logic            valid_id;
    logic            ready_id;
    logic [XLEN-1:0] pc_id;
    logic [ILEN-1:0] inst_id;
    logic            valid_ex;
    logic            ready_ex;
    logic [XLEN-1:0] pc_ex;
    logic [ILEN-1:0] inst_ex;
    decode_pkg::op_e op;
    logic [XLEN-1:0] src_a;
    logic [XLEN-1:0] src_b;
    logic [XLEN-1:0] imm;
    logic            ex_valid;
    logic [ILEN-1:0] ex_inst;
    logic [XLEN-1:0] gpr [decode_pkg::NUM_REGS];  // register file model, also drives the DUT
    logic            branch_flush;

    logic [ILEN-1:0] rec_inst [$];                // one entry per file record
    logic            rec_exv [$];
    logic [ILEN-1:0] rec_exi [$];
    logic [7:0]      rec_rdy [$];
    logic            rec_flush [$];
    decode_pkg::op_e rec_op [$];
    logic [XLEN-1:0] rec_imm [$];
    logic [15:0]     rec_src [$];
    logic [31:0]     lcg_state = 32'h3dd0e5e6;
    logic [XLEN-1:0] next_pc = 64'h0000_0000_8000_0000;
    int              num_records = 0;

    always #(CLK_PERIOD / 2) clk = ~clk;

    decode_stage #(.DEPTH(DEPTH), .ALMOST_FULL(ALMOST_FULL)) dut0 (
        .clk(clk), .rst(rst), .valid_id(valid_id), .ready_id(ready_id),
        .pc_id(pc_id), .inst_id(inst_id), .valid_ex(valid_ex), .ready_ex(ready_ex),
        .pc_ex(pc_ex), .inst_ex(inst_ex), .op(op), .src_a(src_a), .src_b(src_b),
        .imm(imm), .ex_valid(ex_valid), .ex_inst(ex_inst), .gpr(gpr),
        .mtvec(MTVEC_WORD), .mepc(MEPC_WORD), .mcause(MCAUSE_WORD),
        .mstatus(MSTATUS_WORD), .branch_flush(branch_flush)
    );

    bind decode_stage decode_stage_assert #(.DEPTH(DEPTH)) assert0 (
        .clk(clk), .rst(rst), .valid_ex(valid_ex), .ex_valid(ex_valid), .ex_inst(ex_inst),
        .buf_wr(buf_wr), .buf_count(fetch_buffer0.count), .id_valid(id_valid),
        .id_inst(id_inst), .op(op)
    );

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic check_op(input decode_pkg::op_e got, input decode_pkg::op_e exp);
        if (got !== exp)
            abort_run($sformatf("mismatch at %0t: op got %s expected %s",
                                $time, got.name(), exp.name()));
    endtask

    task automatic check_word(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp,
                              input string what);
        if (got !== exp)
            abort_run($sformatf("mismatch at %0t: %s got %h expected %h", $time, what, got, exp));
    endtask

    task automatic check_inst(input logic [ILEN-1:0] got, input logic [ILEN-1:0] exp);
        if (got !== exp)
            abort_run($sformatf("mismatch at %0t: inst_ex got %h expected %h", $time, got, exp));
    endtask

    task automatic check_pc(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp);
        if (got !== exp)
            abort_run($sformatf("mismatch at %0t: pc_ex got %h expected %h", $time, got, exp));
    endtask

    // tag 1000 reads gpr[rs2], 2000 is zero, anything else names a csr
    function automatic logic [XLEN-1:0] expected_src_b(input int idx);
        logic [15:0] tag;
        tag = rec_src[idx];
        if (tag == 16'h1000) return gpr[rec_inst[idx][24:20]];
        if (tag == 16'h2000) return '0;
        case (tag[11:0])
            12'h300: return MSTATUS_WORD;
            12'h305: return MTVEC_WORD;
            12'h341: return MEPC_WORD;
            12'h342: return MCAUSE_WORD;
            default: return '0;
        endcase
    endfunction

    // load in execute writing a register the decoded inst reads
    function automatic bit load_use_expected(input int idx);
        logic [ILEN-1:0] ex_word;
        logic [ILEN-1:0] id_word;
        bit              rs2_used;
        ex_word  = rec_exi[idx];
        id_word  = rec_inst[idx];
        rs2_used = (rec_op[idx] == decode_pkg::op_branch) ||
                   (rec_op[idx] == decode_pkg::op_store) ||
                   (rec_op[idx] == decode_pkg::op_alu_r) ||
                   (rec_op[idx] == decode_pkg::op_alu_rw);
        return rec_exv[idx] && (ex_word[6:0] == 7'b0000011) &&
               ((ex_word[11:7] == id_word[19:15]) ||
                (rs2_used && ex_word[11:7] == id_word[24:20]));
    endfunction

    task automatic read_records();
        int              fd;
        string           line;
        logic [31:0]     f_inst;
        logic [31:0]     f_exv;
        logic [31:0]     f_exi;
        logic [31:0]     f_rdy;
        logic [31:0]     f_flush;
        logic [31:0]     f_op;
        logic [XLEN-1:0] f_imm;
        logic [31:0]     f_src;
        fd = $fopen("sim/decode_input.txt", "r");
        if (fd == 0) abort_run("cannot open the stimulus file sim/decode_input.txt");
        while (!$feof(fd)) begin
            if ($fgets(line, fd) > 0 &&
                $sscanf(line, "%h %h %h %h %h %h %h %h", f_inst, f_exv, f_exi, f_rdy,
                        f_flush, f_op, f_imm, f_src) == 8) begin   // comment lines fail the scan
                rec_inst.push_back(f_inst);
                rec_exv.push_back(f_exv[0]);
                rec_exi.push_back(f_exi);
                rec_rdy.push_back(f_rdy[7:0]);
                rec_flush.push_back(f_flush[0]);
                rec_op.push_back(decode_pkg::op_e'(f_op[4:0]));
                rec_imm.push_back(f_imm);
                rec_src.push_back(f_src[15:0]);
            end
        end
        $fclose(fd);
        if (rec_inst.size() == 0) abort_run("the stimulus file holds no records");
        num_records = rec_inst.size();
    endtask

    task automatic drive_item(input int idx);
        valid_id = 1'b1;
        pc_id    = next_pc;
        inst_id  = rec_inst[idx];
        next_pc  = next_pc + 64'd4;                   // sequential pcs
    endtask

    task automatic check_item(input int idx, input logic [XLEN-1:0] pc);
        check_pc(pc_ex, pc);
        check_inst(inst_ex, rec_inst[idx]);
        check_op(op, rec_op[idx]);
        check_word(imm, rec_imm[idx], "imm");
        check_word(src_a, gpr[rec_inst[idx][19:15]], "src_a");
        check_word(src_b, expected_src_b(idx), "src_b");
    endtask

    // one item, ready_ex from the record's pattern, wait until execute takes it
    task automatic run_record(input int idx);
        int              cyc;
        bit              seen;
        bit              hazard;
        logic [XLEN-1:0] pc;
        hazard = load_use_expected(idx);
        pc     = next_pc;
        drive_item(idx);
        ex_valid = rec_exv[idx];
        ex_inst  = rec_exi[idx];
        ready_ex = rec_rdy[idx][0];
        cyc      = 0;
        seen     = 1'b0;
        while (!seen) begin
            @(negedge clk);
            if (hazard && ex_valid && valid_ex)
                abort_run("load-use hazard did not stall the decode stage");
            if (cyc == 1 && !hazard && rec_rdy[idx][0] && !valid_ex)
                abort_run("an unstalled item did not reach execute one edge after it was sent");
            if (valid_ex && ready_ex) begin           // taken by execute at next edge
                check_item(idx, pc);
                seen = 1'b1;
            end
            @(posedge clk);
            #DRIVE_DELAY;
            valid_id = 1'b0;
            cyc++;
            ready_ex = rec_rdy[idx][cyc % 8];
            if (cyc >= HAZARD_CYCLES) ex_valid = 1'b0;   // load leaves execute
        end
    endtask

    // two stalled items, then a flush; neither may ever reach execute
    task automatic run_flush(input int idx);
        ready_ex = 1'b0;
        ex_valid = 1'b0;
        drive_item(idx);
        @(posedge clk);
        #DRIVE_DELAY;
        drive_item(idx);
        @(posedge clk);
        #DRIVE_DELAY;
        valid_id     = 1'b0;
        branch_flush = 1'b1;
        @(posedge clk);
        #DRIVE_DELAY;
        branch_flush = 1'b0;
        ready_ex     = 1'b1;
        repeat (4) begin
            @(negedge clk);
            if (valid_ex) abort_run("an item presented before the flush reached execute");
            if (!ready_id) abort_run("ready_id stayed low after the flush");
            @(posedge clk);
            #DRIVE_DELAY;
        end
    endtask

    // fill the buffer with execute stalled, then drain with a random ready_ex
    task automatic fill_and_drain();
        int              clean [$];
        int              exp_idx [$];
        logic [XLEN-1:0] exp_pc [$];
        int              n;
        logic [31:0]     rnd;
        foreach (rec_inst[i]) begin
            if (!rec_exv[i] && !rec_flush[i]) clean.push_back(i);
        end
        ready_ex = 1'b0;
        ex_valid = 1'b0;
        n        = 0;
        while (ready_id && n < DEPTH) begin           // ready_id settled since the edge
            exp_idx.push_back(clean[n % clean.size()]);
            exp_pc.push_back(next_pc);
            drive_item(clean[n % clean.size()]);
            n++;
            @(posedge clk);
            #DRIVE_DELAY;
            valid_id = 1'b0;
        end
        if (ready_id) abort_run("ready_id never fell while execute was stalled");
        if (n < ALMOST_FULL)
            abort_run($sformatf("ready_id fell after only %0d accepted items", n));
        while (exp_idx.size() > 0) begin
            rnd      = lcg_next();
            ready_ex = rnd[16];
            @(negedge clk);
            if (valid_ex && ready_ex) check_item(exp_idx.pop_front(), exp_pc.pop_front());
            @(posedge clk);
            #DRIVE_DELAY;
        end
        ready_ex = 1'b1;
        @(negedge clk);
        if (valid_ex) abort_run("an item left the decode stage twice");
    endtask

    initial begin
        wait (num_records > 0);
        #(CLK_PERIOD * (RESET_CYCLES + 40 * (num_records + DEPTH)));
        abort_run("watchdog expired before all items reached execute");
    end

    initial begin
        rst          = 1'b1;
        valid_id     = 1'b0;
        pc_id        = '0;
        inst_id      = '0;
        ready_ex     = 1'b0;
        ex_valid     = 1'b0;
        ex_inst      = '0;
        branch_flush = 1'b0;
        gpr[0]       = '0;                            // x0 hardwired
        for (int r = 1; r < decode_pkg::NUM_REGS; r++) gpr[r] = {lcg_next(), lcg_next()};
        read_records();
        repeat (RESET_CYCLES - 1) @(posedge clk);
        @(negedge clk);
        if (valid_ex !== 1'b0 || ready_id !== 1'b1 || op !== decode_pkg::op_illegal ||
            pc_ex !== '0 || inst_ex !== '0)
            abort_run("decode stage outputs not idle during reset");
        @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;
        for (int i = 0; i < num_records; i++) begin
            if (rec_flush[i]) run_flush(i);
            else run_record(i);
        end
        fill_and_drain();
        $display("sim passed");
        $finish;
    end

endmodule

//--- sim/decode_stage_assert.sv
`timescale 1ns/1ps

module decode_stage_assert #(
    parameter int DEPTH = 16
) (
    input logic                        clk,
    input logic                        rst,
    input logic                        valid_ex,
    input logic                        ex_valid,
    input logic [decode_pkg::ILEN-1:0] ex_inst,
    input logic                        buf_wr,
    input logic [$clog2(DEPTH+1)-1:0]  buf_count,
    input logic                        id_valid,
    input logic [decode_pkg::ILEN-1:0] id_inst,
    input decode_pkg::op_e             op
);

    // decode register comes up empty one edge after reset
    reset_idle: assert property (@(posedge clk) rst |=> !valid_ex)
        else $error("valid_ex high in the cycle after reset");

    // load in execute writing the held inst's rs1, item must stay out of execute
    load_use_bubble: assert property (@(posedge clk) disable iff (rst)
        (id_valid && ex_valid && ex_inst[6:0] == 7'b0000011 &&
         ex_inst[11:7] == id_inst[19:15]) |-> !valid_ex)
        else $error("valid_ex high during a load-use hazard on rs1");

    no_overflow: assert property (@(posedge clk) disable iff (rst) buf_wr |-> buf_count != DEPTH)
        else $error("fetch buffer written while full");

    empty_is_illegal: assert property (@(posedge clk) !id_valid |-> op == decode_pkg::op_illegal)
        else $error("op not op_illegal with an empty decode register");

endmodule

//--- source/decode_stage.sv
`timescale 1ns/1ps

module decode_stage #(
    parameter int DEPTH       = 16,
    parameter int ALMOST_FULL = 12
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        valid_id,
    output logic                        ready_id,
    input  logic [decode_pkg::XLEN-1:0] pc_id,
    input  logic [decode_pkg::ILEN-1:0] inst_id,
    output logic                        valid_ex,
    input  logic                        ready_ex,
    output logic [decode_pkg::XLEN-1:0] pc_ex,
    output logic [decode_pkg::ILEN-1:0] inst_ex,
    output decode_pkg::op_e             op,
    output logic [decode_pkg::XLEN-1:0] src_a,
    output logic [decode_pkg::XLEN-1:0] src_b,
    output logic [decode_pkg::XLEN-1:0] imm,
    input  logic                        ex_valid,
    input  logic [decode_pkg::ILEN-1:0] ex_inst,
    input  logic [decode_pkg::XLEN-1:0] gpr [decode_pkg::NUM_REGS],
    input  logic [decode_pkg::XLEN-1:0] mtvec,
    input  logic [decode_pkg::XLEN-1:0] mepc,
    input  logic [decode_pkg::XLEN-1:0] mcause,
    input  logic [decode_pkg::XLEN-1:0] mstatus,
    input  logic                        branch_flush
);

    logic                              advance;
    logic                              block;
    logic                              buf_wr;
    logic                              buf_empty;
    logic                              buf_almost_full;
    logic [decode_pkg::XLEN-1:0]       head_pc;
    logic [decode_pkg::ILEN-1:0]       head_inst;
    logic                              id_valid;
    logic [decode_pkg::XLEN-1:0]       id_pc;
    logic [decode_pkg::ILEN-1:0]       id_inst;
    logic [decode_pkg::REG_ADDR_W-1:0] rs1;
    logic [decode_pkg::REG_ADDR_W-1:0] rs2;
    logic                              uses_rs2;

    assign advance  = ready_ex && !block;             // single stage enable
    assign buf_wr   = valid_id && !(buf_empty && advance);   // else bypass to decode_reg
    assign ready_id = !buf_almost_full;               // advisory, writes always taken

    fetch_buffer #(.DEPTH(DEPTH), .ALMOST_FULL(ALMOST_FULL)) fetch_buffer0 (
        .clk(clk), .rst(rst), .flush(branch_flush),
        .wr_en(buf_wr), .wr_pc(pc_id), .wr_inst(inst_id), .rd_en(advance),
        .head_pc(head_pc), .head_inst(head_inst),
        .empty(buf_empty), .almost_full(buf_almost_full)
    );

    decode_reg decode_reg0 (
        .clk(clk), .rst(rst), .flush(branch_flush), .advance(advance),
        .buf_empty(buf_empty), .in_valid(valid_id), .in_pc(pc_id), .in_inst(inst_id),
        .head_pc(head_pc), .head_inst(head_inst),
        .id_valid(id_valid), .id_pc(id_pc), .id_inst(id_inst)
    );

    load_interlock load_interlock0 (
        .id_valid(id_valid), .id_inst(id_inst), .uses_rs2(uses_rs2),
        .ex_valid(ex_valid), .ex_inst(ex_inst), .block(block)
    );

    inst_decoder inst_decoder0 (
        .id_valid(id_valid), .id_inst(id_inst),
        .op(op), .rs1(rs1), .rs2(rs2), .uses_rs2(uses_rs2)
    );

    operand_select operand_select0 (
        .id_inst(id_inst), .op(op), .rs1(rs1), .rs2(rs2), .gpr(gpr),
        .mtvec(mtvec), .mepc(mepc), .mcause(mcause), .mstatus(mstatus),
        .src_a(src_a), .src_b(src_b), .imm(imm)
    );

    // bubble toward execute while the load-use stall is up
    assign valid_ex = block ? 1'b0 : id_valid;
    assign pc_ex    = block ? '0 : id_pc;
    assign inst_ex  = block ? '0 : id_inst;

endmodule

//--- source/operand_select.sv
`timescale 1ns/1ps

module operand_select (
    input  logic [decode_pkg::ILEN-1:0]       id_inst,
    input  decode_pkg::op_e                   op,
    input  logic [decode_pkg::REG_ADDR_W-1:0] rs1,
    input  logic [decode_pkg::REG_ADDR_W-1:0] rs2,
    input  logic [decode_pkg::XLEN-1:0]       gpr [decode_pkg::NUM_REGS],
    input  logic [decode_pkg::XLEN-1:0]       mtvec,
    input  logic [decode_pkg::XLEN-1:0]       mepc,
    input  logic [decode_pkg::XLEN-1:0]       mcause,
    input  logic [decode_pkg::XLEN-1:0]       mstatus,
    output logic [decode_pkg::XLEN-1:0]       src_a,
    output logic [decode_pkg::XLEN-1:0]       src_b,
    output logic [decode_pkg::XLEN-1:0]       imm
);

    localparam int XL = decode_pkg::XLEN;

    logic [XL-1:0] imm_i;
    logic [XL-1:0] imm_s;
    logic [XL-1:0] imm_b;
    logic [XL-1:0] imm_u;
    logic [XL-1:0] imm_j;
    logic [XL-1:0] csr_word;

    // all sign-extended from inst[31]
    assign imm_i = {{(XL-12){id_inst[31]}}, id_inst[31:20]};
    assign imm_s = {{(XL-12){id_inst[31]}}, id_inst[31:25], id_inst[11:7]};
    assign imm_b = {{(XL-13){id_inst[31]}}, id_inst[31], id_inst[7], id_inst[30:25],
                    id_inst[11:8], 1'b0};
    assign imm_u = {{(XL-32){id_inst[31]}}, id_inst[31:12], 12'b0};
    assign imm_j = {{(XL-21){id_inst[31]}}, id_inst[31], id_inst[19:12], id_inst[20],
                    id_inst[30:21], 1'b0};

    always_comb begin
        case (imm_i[11:0])                            // csr address field
            decode_pkg::CSR_MSTATUS: csr_word = mstatus;
            decode_pkg::CSR_MTVEC:   csr_word = mtvec;
            decode_pkg::CSR_MEPC:    csr_word = mepc;
            decode_pkg::CSR_MCAUSE:  csr_word = mcause;
            default:                 csr_word = '0;   // unimplemented csr reads zero
        endcase
    end

    always_comb begin
        case (op)
            decode_pkg::op_lui, decode_pkg::op_auipc: imm = imm_u;
            decode_pkg::op_jal:                       imm = imm_j;
            decode_pkg::op_store:                     imm = imm_s;
            decode_pkg::op_branch:                    imm = imm_b;
            default:                                  imm = imm_i;
        endcase
        case (op)
            decode_pkg::op_csrrw, decode_pkg::op_csrrs: src_b = csr_word;
            decode_pkg::op_ecall:                       src_b = mtvec;   // trap target
            decode_pkg::op_mret:                        src_b = mepc;    // return pc
            default:                                    src_b = gpr[rs2];
        endcase
    end

    assign src_a = gpr[rs1];

endmodule

//--- source/inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder (
    input  logic                              id_valid,
    input  logic [decode_pkg::ILEN-1:0]       id_inst,
    output decode_pkg::op_e                   op,
    output logic [decode_pkg::REG_ADDR_W-1:0] rs1,
    output logic [decode_pkg::REG_ADDR_W-1:0] rs2,
    output logic                              uses_rs2
);

    logic [decode_pkg::ILEN-1:0] inst;
    decode_pkg::opcode_e         opcode;
    logic [2:0]                  funct3;
    logic [6:0]                  funct7;

    assign inst   = id_valid ? id_inst : '0;          // empty register decodes as zero
    assign opcode = decode_pkg::opcode_e'(inst[6:0]);
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];

    always_comb begin
        op = decode_pkg::op_illegal;                  // anything unlisted
        case (opcode)
            decode_pkg::lui:    op = decode_pkg::op_lui;
            decode_pkg::auipc:  op = decode_pkg::op_auipc;
            decode_pkg::jal:    op = decode_pkg::op_jal;
            decode_pkg::jalr:   if (funct3 == 3'b000) op = decode_pkg::op_jalr;
            decode_pkg::branch: if (funct3[2:1] != 2'b01) op = decode_pkg::op_branch;
            decode_pkg::load:   if (funct3 != 3'b111) op = decode_pkg::op_load;
            decode_pkg::store:  if (funct3[2] == 1'b0) op = decode_pkg::op_store;
            decode_pkg::op_imm: begin
                if (funct3 == 3'b001) begin           // slli, 6-bit shamt
                    if (funct7[6:1] == 6'b000000) op = decode_pkg::op_alu_i;
                end else if (funct3 == 3'b101) begin  // srli / srai
                    if (funct7[6:1] == 6'b000000 || funct7[6:1] == 6'b010000)
                        op = decode_pkg::op_alu_i;
                end else begin
                    op = decode_pkg::op_alu_i;
                end
            end
            decode_pkg::op_imm_32: begin
                if (funct3 == 3'b000) op = decode_pkg::op_alu_iw;      // addiw
                else if (funct3 == 3'b001 && funct7 == 7'b0000000) op = decode_pkg::op_alu_iw;
                else if (funct3 == 3'b101 && (funct7 == 7'b0000000 || funct7 == 7'b0100000))
                    op = decode_pkg::op_alu_iw;
            end
            decode_pkg::op: begin
                if (funct7 == 7'b0000000 || funct7 == 7'b0000001) op = decode_pkg::op_alu_r;
                else if (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101))
                    op = decode_pkg::op_alu_r;        // sub, sra
            end
            decode_pkg::op_32: begin
                if (funct7 == 7'b0000000 && (funct3 == 3'b000 || funct3 == 3'b001 ||
                                             funct3 == 3'b101))
                    op = decode_pkg::op_alu_rw;
                else if (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101))
                    op = decode_pkg::op_alu_rw;       // subw, sraw
                else if (funct7 == 7'b0000001 && funct3 != 3'b001 && funct3 != 3'b010 &&
                         funct3 != 3'b011)
                    op = decode_pkg::op_alu_rw;       // m ext word ops
            end
            decode_pkg::system: begin
                if (inst == decode_pkg::ECALL_WORD) op = decode_pkg::op_ecall;
                else if (inst == decode_pkg::MRET_WORD) op = decode_pkg::op_mret;
                else if (inst == decode_pkg::EBREAK_WORD) op = decode_pkg::op_ebreak;
                else if (funct3 == 3'b001) op = decode_pkg::op_csrrw;
                else if (funct3 == 3'b010) op = decode_pkg::op_csrrs;
            end
            default: op = decode_pkg::op_illegal;
        endcase
    end

    // classes whose rs2 field is a real source
    assign uses_rs2 = (op == decode_pkg::op_branch) || (op == decode_pkg::op_store) ||
                      (op == decode_pkg::op_alu_r)  || (op == decode_pkg::op_alu_rw);

endmodule

//--- source/load_interlock.sv
`timescale 1ns/1ps

module load_interlock (
    input  logic                       id_valid,
    input  logic [decode_pkg::ILEN-1:0] id_inst,
    input  logic                       uses_rs2,
    input  logic                       ex_valid,
    input  logic [decode_pkg::ILEN-1:0] ex_inst,
    output logic                       block
);

    logic [decode_pkg::REG_ADDR_W-1:0] ex_rd;
    logic                              ex_loading;
    logic                              rs1_hit;
    logic                              rs2_hit;

    assign ex_rd      = ex_inst[11:7];
    assign ex_loading = (decode_pkg::opcode_e'(ex_inst[6:0]) == decode_pkg::load);

    // x0 compared like any other register, harmless extra stall
    assign rs1_hit = (ex_rd == id_inst[19:15]);
    assign rs2_hit = (ex_rd == id_inst[24:20]) && uses_rs2;

    // load data not ready until after execute, hold decode one cycle
    assign block = id_valid && ex_valid && ex_loading && (rs1_hit || rs2_hit);

endmodule

//--- source/decode_reg.sv
`timescale 1ns/1ps

module decode_reg (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       flush,
    input  logic                       advance,
    input  logic                       buf_empty,
    input  logic                       in_valid,
    input  logic [decode_pkg::XLEN-1:0] in_pc,
    input  logic [decode_pkg::ILEN-1:0] in_inst,
    input  logic [decode_pkg::XLEN-1:0] head_pc,
    input  logic [decode_pkg::ILEN-1:0] head_inst,
    output logic                       id_valid,
    output logic [decode_pkg::XLEN-1:0] id_pc,
    output logic [decode_pkg::ILEN-1:0] id_inst
);

    logic                        next_valid;
    logic [decode_pkg::XLEN-1:0] next_pc;
    logic [decode_pkg::ILEN-1:0] next_inst;

    always_comb begin
        if (!buf_empty) begin
            next_valid = 1'b1;                        // buffer head is always valid
            next_pc    = head_pc;
            next_inst  = head_inst;
        end else if (in_valid) begin
            next_valid = 1'b1;                        // bypass around empty buffer
            next_pc    = in_pc;
            next_inst  = in_inst;
        end else begin
            next_valid = 1'b0;                        // bubble, keep payload zero
            next_pc    = '0;
            next_inst  = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            id_valid <= 1'b0;
            id_pc    <= '0;
            id_inst  <= '0;
        end else if (advance) begin                   // hold on stall or block
            id_valid <= next_valid;
            id_pc    <= next_pc;
            id_inst  <= next_inst;
        end
    end

endmodule

//--- source/fetch_buffer.sv
`timescale 1ns/1ps

module fetch_buffer #(
    parameter int DEPTH       = 16,
    parameter int ALMOST_FULL = 12
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       flush,
    input  logic                       wr_en,
    input  logic [decode_pkg::XLEN-1:0] wr_pc,
    input  logic [decode_pkg::ILEN-1:0] wr_inst,
    input  logic                       rd_en,
    output logic [decode_pkg::XLEN-1:0] head_pc,
    output logic [decode_pkg::ILEN-1:0] head_inst,
    output logic                       empty,
    output logic                       almost_full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);         // must hold DEPTH itself

    logic [decode_pkg::XLEN-1:0] mem_pc   [DEPTH];
    logic [decode_pkg::ILEN-1:0] mem_inst [DEPTH];
    logic [PTR_W-1:0]            wr_ptr;
    logic [PTR_W-1:0]            rd_ptr;
    logic [CNT_W-1:0]            count;
    logic                        full;
    logic                        do_wr;
    logic                        do_rd;

    assign full  = (count == CNT_W'(DEPTH));
    assign do_wr = wr_en && !full;                    // overflow dropped, producer obeys ready_id
    assign do_rd = rd_en && !empty;                   // read of empty buffer ignored

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem_pc[wr_ptr]   <= wr_pc;                // payload, no reset
            mem_inst[wr_ptr] <= wr_inst;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_rd) rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;              // both or neither
            endcase
        end
    end

    assign head_pc     = mem_pc[rd_ptr];              // combinational head
    assign head_inst   = mem_inst[rd_ptr];
    assign empty       = (count == '0);
    assign almost_full = (count >= CNT_W'(ALMOST_FULL));

endmodule

//--- source/decode_pkg.sv
package decode_pkg;

    localparam int XLEN       = 64;                   // rv64 datapath
    localparam int ILEN       = 32;                   // base isa, no compressed
    localparam int REG_ADDR_W = 5;                    // x0..x31
    localparam int NUM_REGS   = 32;

    // major opcode field, inst[6:0]
    typedef enum logic [6:0] {
        lui       = 7'b0110111,
        auipc     = 7'b0010111,
        jal       = 7'b1101111,
        jalr      = 7'b1100111,
        branch    = 7'b1100011,
        load      = 7'b0000011,
        store     = 7'b0100011,
        op_imm    = 7'b0010011,
        op_imm_32 = 7'b0011011,                       // addiw and word shifts
        op        = 7'b0110011,
        op_32     = 7'b0111011,                       // word reg-reg incl. m ext
        system    = 7'b1110011
    } opcode_e;

    // operation class handed to execute, funct bits travel in inst_ex
    typedef enum logic [4:0] {
        op_illegal = 5'd0,                            // reset and bubble value
        op_lui,
        op_auipc,
        op_jal,
        op_jalr,
        op_branch,
        op_load,
        op_store,
        op_alu_i,
        op_alu_iw,
        op_alu_r,
        op_alu_rw,
        op_csrrw,
        op_csrrs,
        op_ecall,
        op_mret,
        op_ebreak
    } op_e;

    localparam logic [11:0] CSR_MSTATUS = 12'h300;
    localparam logic [11:0] CSR_MTVEC   = 12'h305;
    localparam logic [11:0] CSR_MEPC    = 12'h341;
    localparam logic [11:0] CSR_MCAUSE  = 12'h342;

    localparam logic [31:0] ECALL_WORD  = 32'h0000_0073;
    localparam logic [31:0] MRET_WORD   = 32'h3020_0073;
    localparam logic [31:0] EBREAK_WORD = 32'h0010_0073;

endpackage
